// ==== include/rom_cfg.svh ====
`ifndef ROM_CFG_SVH
`define ROM_CFG_SVH

// SDRAM word address width, 16-bit words
`define ROM_SDRAM_AW 22

// client address widths
`define ROM_SLOT0_AW 12
`define ROM_SLOT1_AW 12
`define ROM_SLOT2_AW 10

// client data widths
`define ROM_SLOT0_DW 8
`define ROM_SLOT1_DW 16
`define ROM_SLOT2_DW 32

// start of each slot region, in SDRAM words
`define ROM_SLOT0_OFFSET 22'h00_0000
`define ROM_SLOT1_OFFSET 22'h01_0000
`define ROM_SLOT2_OFFSET 22'h02_0000

`endif

// ==== rtl/rom_pkg.sv ====
`include "rom_cfg.svh"

package rom_pkg;

    // word address into the SDRAM
    typedef logic [`ROM_SDRAM_AW-1:0] sdram_addr_t;

    // two consecutive 16-bit words, lower address in bits 15:0
    typedef logic [31:0] sdram_word_t;

    // arbiter FSM
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WAIT_ACK,
        ARB_WAIT_DATA
    } arb_state_t;

endpackage

// ==== rtl/rom_req_if.sv ====
`timescale 1ns/100ps

interface rom_req_if;

    // miss request from the slot
    logic                 req;
    rom_pkg::sdram_addr_t addr;

    // arbiter side
    logic                 grant;
    rom_pkg::sdram_word_t data;
    logic                 data_ok;

    modport cache (
        output req,
        output addr,
        input  grant,
        input  data,
        input  data_ok
    );

    modport arbiter (
        input  req,
        input  addr,
        output grant,
        output data,
        output data_ok
    );

endinterface

// ==== rtl/rom_slot_cache.sv ====
`timescale 1ns/100ps

module rom_slot_cache #(
    parameter int                   AW     = 12,
    parameter int                   DW     = 8,
    parameter rom_pkg::sdram_addr_t OFFSET = '0
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          cs,
    input  logic [AW-1:0] addr,
    output logic [DW-1:0] dout,
    output logic          ok,
    rom_req_if.cache      bus
);

    localparam int SAW = $bits(rom_pkg::sdram_addr_t);

    rom_pkg::sdram_addr_t word_addr;
    rom_pkg::sdram_addr_t word_diff;
    rom_pkg::sdram_addr_t tag;
    rom_pkg::sdram_addr_t req_addr;
    rom_pkg::sdram_word_t line;
    logic                 valid;
    logic                 in_line;
    logic                 hit;
    logic                 req_q;
    logic                 ok_q;
    logic [AW-1:0]        addr_q;
    logic [DW-1:0]        lane_data;
    logic [DW-1:0]        dout_q;
    logic                 fill;

    // client address scaled to 16-bit words, then moved into the slot region
    generate
        if (DW == 32) begin : g_addr32
            assign word_addr = {{(SAW-AW-1){1'b0}}, addr, 1'b0} + OFFSET;
        end else if (DW == 16) begin : g_addr16
            assign word_addr = {{(SAW-AW){1'b0}}, addr} + OFFSET;
        end else begin : g_addr8
            assign word_addr = {{(SAW-AW+1){1'b0}}, addr[AW-1:1]} + OFFSET;
        end
    endgenerate

    // line covers tag and tag+1, a 32-bit read needs both
    assign word_diff = word_addr - tag;
    assign in_line   = (DW == 32) ? (word_diff == '0) : (word_diff[SAW-1:1] == '0);
    assign hit       = valid && in_line;

    // little-endian lane select out of the cached line
    generate
        if (DW == 32) begin : g_lane32
            assign lane_data = line;
        end else if (DW == 16) begin : g_lane16
            assign lane_data = word_diff[0] ? line[31:16] : line[15:0];
        end else begin : g_lane8
            logic [15:0] half;

            assign half      = word_diff[0] ? line[31:16] : line[15:0];
            assign lane_data = addr[0] ? half[15:8] : half[7:0];
        end
    endgenerate

    assign fill = bus.grant && bus.data_ok;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= 1'b0;
            req_q <= 1'b0;
            ok_q  <= 1'b0;
        end else begin
            ok_q <= cs && hit;
            if (fill) begin
                valid <= 1'b1;
                req_q <= 1'b0;
            end else if (!req_q) begin
                req_q <= cs && !hit;
            end
        end
    end

    always_ff @(posedge clk) begin
        addr_q <= addr;
        dout_q <= lane_data;
        // request address frozen while the miss is pending
        if (!req_q) begin
            req_addr <= word_addr;
        end
        if (fill) begin
            line <= bus.data;
            tag  <= req_addr;
        end
    end

    // a changed address invalidates the registered result
    assign ok   = cs && ok_q && (addr == addr_q);
    assign dout = dout_q;

    assign bus.req  = req_q;
    assign bus.addr = req_addr;

endmodule

// ==== rtl/rom_slot_arbiter.sv ====
`timescale 1ns/100ps

module rom_slot_arbiter (
    input  logic                 clk,
    input  logic                 rst,
    rom_req_if.arbiter           slot0,
    rom_req_if.arbiter           slot1,
    rom_req_if.arbiter           slot2,
    output logic                 sdram_req,
    output rom_pkg::sdram_addr_t sdram_addr,
    input  logic                 sdram_ack,
    input  logic                 data_rdy,
    input  rom_pkg::sdram_word_t data_read
);

    rom_pkg::arb_state_t  state;
    rom_pkg::sdram_addr_t sel_addr;
    logic [2:0]           req_vec;
    logic [2:0]           grant_vec;
    logic [2:0]           active;
    logic [2:0]           sel;
    logic [2:0]           ok_vec;
    logic                 done;
    logic                 launch;

    assign req_vec = {slot2.req, slot1.req, slot0.req};
    // a granted slot keeps req high until its data is back
    assign active  = req_vec & ~grant_vec;

    // slot 0 wins
    always_comb begin
        sel      = 3'b000;
        sel_addr = slot2.addr;
        if (active[0]) begin
            sel      = 3'b001;
            sel_addr = slot0.addr;
        end else if (active[1]) begin
            sel      = 3'b010;
            sel_addr = slot1.addr;
        end else if (active[2]) begin
            sel      = 3'b100;
            sel_addr = slot2.addr;
        end
    end

    assign done   = (state == rom_pkg::ARB_WAIT_DATA) && data_rdy;
    // next read can start in the same cycle the previous data lands
    assign launch = |active && ((state == rom_pkg::ARB_IDLE) || done);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= rom_pkg::ARB_IDLE;
            sdram_req <= 1'b0;
            grant_vec <= 3'b000;
        end else begin
            if (state == rom_pkg::ARB_WAIT_ACK && sdram_ack) begin
                sdram_req <= 1'b0;
                state     <= rom_pkg::ARB_WAIT_DATA;
            end
            if (launch) begin
                sdram_req <= 1'b1;
                grant_vec <= sel;
                state     <= rom_pkg::ARB_WAIT_ACK;
            end else if (done) begin
                grant_vec <= 3'b000;
                state     <= rom_pkg::ARB_IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            sdram_addr <= sel_addr;
        end
    end

    assign ok_vec = grant_vec & {3{done}};

    assign slot0.grant   = grant_vec[0];
    assign slot1.grant   = grant_vec[1];
    assign slot2.grant   = grant_vec[2];
    assign slot0.data_ok = ok_vec[0];
    assign slot1.data_ok = ok_vec[1];
    assign slot2.data_ok = ok_vec[2];

    // every slot sees the word, only the granted one stores it
    assign slot0.data = data_read;
    assign slot1.data = data_read;
    assign slot2.data = data_read;

endmodule

// ==== rtl/rom_slots.sv ====
`timescale 1ns/100ps
`include "rom_cfg.svh"

module rom_slots (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     slot0_cs,
    input  logic [`ROM_SLOT0_AW-1:0] slot0_addr,
    output logic [`ROM_SLOT0_DW-1:0] slot0_dout,
    output logic                     slot0_ok,

    input  logic                     slot1_cs,
    input  logic [`ROM_SLOT1_AW-1:0] slot1_addr,
    output logic [`ROM_SLOT1_DW-1:0] slot1_dout,
    output logic                     slot1_ok,

    input  logic                     slot2_cs,
    input  logic [`ROM_SLOT2_AW-1:0] slot2_addr,
    output logic [`ROM_SLOT2_DW-1:0] slot2_dout,
    output logic                     slot2_ok,

    // SDRAM controller read port
    output logic                     sdram_req,
    output logic [`ROM_SDRAM_AW-1:0] sdram_addr,
    input  logic                     sdram_ack,
    input  logic                     data_rdy,
    input  logic [31:0]              data_read
);

    rom_req_if slot0_bus ();
    rom_req_if slot1_bus ();
    rom_req_if slot2_bus ();

    // slot 0 has the highest priority
    rom_slot_cache #(
        .AW     (`ROM_SLOT0_AW),
        .DW     (`ROM_SLOT0_DW),
        .OFFSET (`ROM_SLOT0_OFFSET)
    ) u_slot0 (
        .clk  (clk),
        .rst  (rst),
        .cs   (slot0_cs),
        .addr (slot0_addr),
        .dout (slot0_dout),
        .ok   (slot0_ok),
        .bus  (slot0_bus.cache)
    );

    rom_slot_cache #(
        .AW     (`ROM_SLOT1_AW),
        .DW     (`ROM_SLOT1_DW),
        .OFFSET (`ROM_SLOT1_OFFSET)
    ) u_slot1 (
        .clk  (clk),
        .rst  (rst),
        .cs   (slot1_cs),
        .addr (slot1_addr),
        .dout (slot1_dout),
        .ok   (slot1_ok),
        .bus  (slot1_bus.cache)
    );

    rom_slot_cache #(
        .AW     (`ROM_SLOT2_AW),
        .DW     (`ROM_SLOT2_DW),
        .OFFSET (`ROM_SLOT2_OFFSET)
    ) u_slot2 (
        .clk  (clk),
        .rst  (rst),
        .cs   (slot2_cs),
        .addr (slot2_addr),
        .dout (slot2_dout),
        .ok   (slot2_ok),
        .bus  (slot2_bus.cache)
    );

    rom_slot_arbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .slot0      (slot0_bus.arbiter),
        .slot1      (slot1_bus.arbiter),
        .slot2      (slot2_bus.arbiter),
        .sdram_req  (sdram_req),
        .sdram_addr (sdram_addr),
        .sdram_ack  (sdram_ack),
        .data_rdy   (data_rdy),
        .data_read  (data_read)
    );

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock #(
    parameter real PERIOD     = 8.0,
    parameter int  RST_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset released on a rising edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== tests/rom_slots_tb.sv ====
`timescale 1ns/100ps
`include "rom_cfg.svh"

module rom_slots_tb;

    localparam int N_SINGLE  = 8;
    localparam int N_RAND    = 40;
    localparam int N_TXN     = 3 * N_SINGLE + 8 + 3 * N_RAND;
    // arbitration plus up to 3 cycles to ack and 6 to data and then the refill
    localparam int WORST_CYC = 14;
    localparam int LIMIT_NS  = (N_TXN * WORST_CYC * 3 + 500) * 8;

    logic                     clk;
    logic                     rst;
    logic                     slot0_cs, slot1_cs, slot2_cs;
    logic                     slot0_ok, slot1_ok, slot2_ok;
    logic [`ROM_SLOT0_AW-1:0] slot0_addr;
    logic [`ROM_SLOT1_AW-1:0] slot1_addr;
    logic [`ROM_SLOT2_AW-1:0] slot2_addr;
    logic [`ROM_SLOT0_DW-1:0] slot0_dout;
    logic [`ROM_SLOT1_DW-1:0] slot1_dout;
    logic [`ROM_SLOT2_DW-1:0] slot2_dout;
    logic                     sdram_req, sdram_ack, data_rdy;
    rom_pkg::sdram_addr_t     sdram_addr;
    rom_pkg::sdram_word_t     data_read;

    integer               seed = 32'h284d;
    int                   errors = 0;
    int                   checks = 0;
    int                   err_mark = 0;
    int                   sd_reads [3];
    int                   exp_reads [3];
    bit                   mdl_valid [3];
    rom_pkg::sdram_addr_t mdl_tag [3];
    rom_pkg::sdram_addr_t exp_addr_q [$];

    tb_clock #(.PERIOD(8.0), .RST_CYCLES(5)) u_clock (.clk(clk), .rst(rst));

    rom_slots UUT (.*);

    // fixed scramble that every address bit reaches
    function automatic logic [15:0] mem_word(input rom_pkg::sdram_addr_t a);
        return a[15:0] ^ {a[5:0], a[21:12]} ^ 16'hc3a5;
    endfunction

    function automatic logic [31:0] addr_mask(input int s);
        case (s)
            0:       return (32'd1 << `ROM_SLOT0_AW) - 1;
            1:       return (32'd1 << `ROM_SLOT1_AW) - 1;
            default: return (32'd1 << `ROM_SLOT2_AW) - 1;
        endcase
    endfunction

    function automatic logic [31:0] rand_addr(input int s);
        return {$random(seed)} & addr_mask(s);
    endfunction

    // two bytes share a word and a 32-bit item spans two words
    function automatic rom_pkg::sdram_addr_t word_of(input int s, input logic [31:0] a);
        case (s)
            0:       return `ROM_SLOT0_OFFSET + rom_pkg::sdram_addr_t'(a >> 1);
            1:       return `ROM_SLOT1_OFFSET + rom_pkg::sdram_addr_t'(a);
            default: return `ROM_SLOT2_OFFSET + rom_pkg::sdram_addr_t'(a << 1);
        endcase
    endfunction

    function automatic logic [31:0] exp_dout(input int s, input logic [31:0] a);
        logic [15:0] lo;
        logic [15:0] hi;
        lo = mem_word(word_of(s, a));
        hi = mem_word(word_of(s, a) + rom_pkg::sdram_addr_t'(1));
        case (s)
            0:       return {24'h0, a[0] ? lo[15:8] : lo[7:0]};
            1:       return {16'h0, lo};
            default: return {hi, lo};
        endcase
    endfunction

    // the line holds the missed word and the one after it
    function automatic bit predict_hit(input int s, input rom_pkg::sdram_addr_t w);
        if (!mdl_valid[s]) return 1'b0;
        if (s == 2) return w == mdl_tag[s];
        return (w == mdl_tag[s]) || (w == mdl_tag[s] + rom_pkg::sdram_addr_t'(1));
    endfunction

    function automatic logic [32:0] slot_out(input int s);
        case (s)
            0:       return {slot0_ok, 24'h0, slot0_dout};
            1:       return {slot1_ok, 16'h0, slot1_dout};
            default: return {slot2_ok, slot2_dout};
        endcase
    endfunction

    task automatic drive_slot(input int s, input logic cs, input logic [31:0] a);
        case (s)
            0: begin
                slot0_cs   <= cs;
                slot0_addr <= a[`ROM_SLOT0_AW-1:0];
            end
            1: begin
                slot1_cs   <= cs;
                slot1_addr <= a[`ROM_SLOT1_AW-1:0];
            end
            default: begin
                slot2_cs   <= cs;
                slot2_addr <= a[`ROM_SLOT2_AW-1:0];
            end
        endcase
    endtask

    task automatic check_dout(
        input int                       s,
        input logic [`ROM_SLOT2_DW-1:0] got,
        input logic [`ROM_SLOT2_DW-1:0] exp
    );
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t slot%0d dout %h, expected %h", $time, s, got, exp);
        end
    endtask

    task automatic check_addr(input rom_pkg::sdram_addr_t got, input rom_pkg::sdram_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t sdram_addr %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[FAIL] %0t %s %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_counts();
        for (int s = 0; s < 3; s++) begin
            check_count($sformatf("slot%0d sdram reads", s), sd_reads[s], exp_reads[s]);
        end
    endtask

    task automatic check_quiet();
        checks++;
        if ({sdram_req, slot0_ok, slot1_ok, slot2_ok} !== 4'b0000) begin
            errors++;
            $display("reset check: sdram_req or a slot ok is not low at %0t", $time);
        end
    endtask

    task automatic finish_test(input int n, input string name);
        $display("test %0d %s: %0d errors", n, name, errors - err_mark);
        err_mark = errors;
    endtask

    // one client read with cs and addr held until ok
    task automatic read_slot(input int s, input logic [31:0] a, input bit track);
        rom_pkg::sdram_addr_t w;
        logic [32:0]          out;
        w = word_of(s, a);
        if (!predict_hit(s, w)) begin
            exp_reads[s]++;
            mdl_valid[s] = 1'b1;
            mdl_tag[s]   = w;
            if (track) exp_addr_q.push_back(w);
        end
        @(posedge clk);
        drive_slot(s, 1'b1, a);
        do begin
            @(negedge clk);
            out = slot_out(s);
        end while (!out[32]);
        check_dout(s, out[31:0], exp_dout(s, a));
    endtask

    // half the reads stay near the last one so the cache gets hits
    task automatic random_traffic(input int s);
        logic [31:0] a;
        int          gap;
        a = rand_addr(s);
        for (int i = 0; i < N_RAND; i++) begin
            a = ({$random(seed)} % 2 == 1) ? ((a + 1) & addr_mask(s)) : rand_addr(s);
            read_slot(s, a, 1'b0);
            gap = {$random(seed)} % 3;
            if (gap > 0) begin
                @(posedge clk);
                drive_slot(s, 1'b0, '0);
                repeat (gap - 1) @(posedge clk);
            end
        end
    endtask

    // SDRAM controller with random ack and data latency and one read at a time
    initial begin
        rom_pkg::sdram_addr_t a;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(posedge clk);
            if (sdram_req === 1'b1) begin
                a = sdram_addr;
                if (a >= `ROM_SLOT2_OFFSET) sd_reads[2]++;
                else if (a >= `ROM_SLOT1_OFFSET) sd_reads[1]++;
                else sd_reads[0]++;
                if (exp_addr_q.size() > 0) check_addr(a, exp_addr_q.pop_front());
                repeat ({$random(seed)} % 4) @(posedge clk);
                sdram_ack <= 1'b1;
                @(posedge clk);
                sdram_ack <= 1'b0;
                repeat ({$random(seed)} % 6) @(posedge clk);
                data_rdy  <= 1'b1;
                data_read <= {mem_word(a + rom_pkg::sdram_addr_t'(1)), mem_word(a)};
                @(posedge clk);
                data_rdy  <= 1'b0;
            end
        end
    end

    initial begin
        #(LIMIT_NS);
        $display("watchdog expired: reads still pending after %0d ns", LIMIT_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [31:0] a;
        logic [31:0] a0;
        logic [31:0] a2;
        slot0_cs   = 1'b0;
        slot1_cs   = 1'b0;
        slot2_cs   = 1'b0;
        slot0_addr = '0;
        slot1_addr = '0;
        slot2_addr = '0;

        @(posedge clk);
        @(negedge clk);
        while (rst) begin
            check_quiet();
            @(negedge clk);
        end
        check_quiet();
        finish_test(1, "reset");

        for (int s = 0; s < 3; s++) begin
            for (int i = 0; i < N_SINGLE; i++) begin
                read_slot(s, rand_addr(s), 1'b1);
            end
        end
        check_counts();
        finish_test(2, "single slot reads");

        // other byte, next halfword, same 32-bit item again
        for (int s = 0; s < 3; s++) begin
            a = rand_addr(s);
            read_slot(s, a, 1'b1);
            read_slot(s, (s == 0) ? a ^ 1 : (s == 1) ? ((a + 1) & addr_mask(s)) : a, 1'b1);
        end
        check_counts();
        finish_test(3, "cache hits");

        do begin
            a0 = rand_addr(0);
            a2 = rand_addr(2);
        end while (predict_hit(0, word_of(0, a0)) || predict_hit(2, word_of(2, a2)));
        exp_addr_q.push_back(word_of(0, a0));
        exp_addr_q.push_back(word_of(2, a2));
        fork
            read_slot(0, a0, 1'b0);
            read_slot(2, a2, 1'b0);
        join
        check_count("unmatched sdram reads", exp_addr_q.size(), 0);
        check_counts();
        finish_test(4, "priority");

        fork
            random_traffic(0);
            random_traffic(1);
            random_traffic(2);
        join
        check_counts();
        finish_test(5, "concurrent traffic");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== rom_slots.f ====
+incdir+include
rtl/rom_pkg.sv
rtl/rom_req_if.sv
rtl/rom_slot_cache.sv
rtl/rom_slot_arbiter.sv
rtl/rom_slots.sv
tests/tb_clock.sv
tests/rom_slots_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the rom_slots testbench with Verilator, run it, then judge the log
cd "$(dirname "$0")" && rm -f sim.log && \
verilator --binary --timing -f rom_slots.f --top-module rom_slots_tb -o rom_slots_sim && \
./obj_dir/rom_slots_sim > sim.log 2>&1 || echo "build or simulation returned an error"
cat sim.log
grep -qx "TEST OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
